/* riscvPkg.sv */
`default_nettype none

package riscvPkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ----------------------------------------------------------------------
    // Instruction field positions
    // ----------------------------------------------------------------------
    localparam int OPCODE_W      = 7;
    localparam int RD_LSB        = 7;
    localparam int FUNCT3_LSB    = 12;
    localparam int FUNCT3_W      = 3;
    localparam int RS1_LSB       = 15;
    localparam int RS2_LSB       = 20;
    localparam int FUNCT7_ALT    = 30;  // Selects SUB and SRA/SRAI

    // Major opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111
    } opcodeE;

    // ALU operations, ADD is zero so a bubble decodes to it
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10   // Operand B straight through, for lui
    } aluOpE;

    // Branch conditions, same encoding as funct3
    typedef enum logic [FUNCT3_W-1:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branchCondE;

endpackage

`default_nettype wire

/* pipePkg.sv */
`default_nettype none

package pipePkg;

    import riscvPkg::*;

    // ----------------------------------------------------------------------
    // Bundles between stages
    // ----------------------------------------------------------------------

    // Decoded control, all zero is a bubble
    typedef struct packed {
        logic       branch;
        logic       jump;       // jal and jalr
        logic       jalr;
        logic       aluSrcImm;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       regWrite;
        aluOpE      aluOp;
        branchCondE branchCond;
    } ctrlBundleT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1Addr;
        logic [REG_ADDR_W-1:0] rs2Addr;
        logic [REG_ADDR_W-1:0] rdAddr;
        logic [XLEN-1:0]       rs1Val;
        logic [XLEN-1:0]       rs2Val;
        logic [XLEN-1:0]       imm;
    } operandBundleT;

    // What leaves EX toward MEM
    typedef struct packed {
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       storeData;
        logic [REG_ADDR_W-1:0] rdAddr;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  memToReg;
    } exResultT;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirectT;

    // ----------------------------------------------------------------------
    // Pipeline constants
    // ----------------------------------------------------------------------
    localparam logic [XLEN-1:0] NOP_INSTR   = 32'h0000_0013;  // addi x0,x0,0
    localparam logic [XLEN-1:0] PC_STEP     = 32'd4;
    localparam ctrlBundleT      BUBBLE_CTRL = '0;

endpackage

`default_nettype wire

/* instrDecoder.sv */
`default_nettype none

module instrDecoder import riscvPkg::*; import pipePkg::*; (
    input  wire logic [XLEN-1:0]       instr,
    input  wire logic                  instrValid,
    output ctrlBundleT                 ctrl,
    output logic [XLEN-1:0]            imm,
    output logic [REG_ADDR_W-1:0]      rs1Addr,
    output logic [REG_ADDR_W-1:0]      rs2Addr,
    output logic [REG_ADDR_W-1:0]      rdAddr,
    output logic                       rs1Used,
    output logic                       rs2Used
);

    logic [XLEN-1:0]     word;
    logic [FUNCT3_W-1:0] funct3;
    logic                altBit;
    aluOpE               functOp;

    assign word    = instrValid ? instr : NOP_INSTR;  // Empty slot becomes a nop
    assign funct3  = word[FUNCT3_LSB +: FUNCT3_W];
    assign altBit  = word[FUNCT7_ALT];
    assign rs1Addr = word[RS1_LSB +: REG_ADDR_W];
    assign rs2Addr = word[RS2_LSB +: REG_ADDR_W];

    // ALU op for OP and OP_IMM, SUB only exists in the register form
    always_comb begin
        case (funct3)
            3'b000:  functOp = (altBit && word[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  functOp = ALU_SLL;
            3'b010:  functOp = ALU_SLT;
            3'b011:  functOp = ALU_SLTU;
            3'b100:  functOp = ALU_XOR;
            3'b101:  functOp = altBit ? ALU_SRA : ALU_SRL;
            3'b110:  functOp = ALU_OR;
            default: functOp = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl    = BUBBLE_CTRL;
        imm     = '0;
        rs1Used = 1'b0;
        rs2Used = 1'b0;

        if (word != NOP_INSTR) begin  // Canonical nop travels as a bubble
            case (opcodeE'(word[OPCODE_W-1:0]))
                OPC_OP: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = functOp;
                    rs1Used       = 1'b1;
                    rs2Used       = 1'b1;
                end
                OPC_OP_IMM: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.aluOp     = functOp;
                    imm            = {{20{word[31]}}, word[31:20]};
                    rs1Used        = 1'b1;
                end
                OPC_LOAD: begin
                    ctrl.memRead   = 1'b1;
                    ctrl.memToReg  = 1'b1;
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    imm            = {{20{word[31]}}, word[31:20]};
                    rs1Used        = 1'b1;
                end
                OPC_STORE: begin
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    imm            = {{20{word[31]}}, word[31:25], word[11:7]};
                    rs1Used        = 1'b1;
                    rs2Used        = 1'b1;
                end
                OPC_BRANCH: begin
                    ctrl.branch     = 1'b1;
                    ctrl.branchCond = branchCondE'(funct3);
                    imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
                    rs1Used         = 1'b1;
                    rs2Used         = 1'b1;
                end
                OPC_JAL: begin
                    ctrl.jump     = 1'b1;
                    ctrl.regWrite = 1'b1;
                    imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
                end
                OPC_JALR: begin
                    ctrl.jump     = 1'b1;
                    ctrl.jalr     = 1'b1;
                    ctrl.regWrite = 1'b1;
                    imm           = {{20{word[31]}}, word[31:20]};
                    rs1Used       = 1'b1;
                end
                OPC_LUI: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.aluOp     = ALU_PASSB;
                    imm            = {word[31:12], 12'b0};
                end
                default: ;  // Unknown opcode stays a bubble
            endcase
        end
    end

    // No destination unless the instruction writes one
    assign rdAddr = ctrl.regWrite ? word[RD_LSB +: REG_ADDR_W] : '0;

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile import riscvPkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [REG_ADDR_W-1:0] rs1Addr,
    input  wire logic [REG_ADDR_W-1:0] rs2Addr,
    output logic [XLEN-1:0]            rs1Val,
    output logic [XLEN-1:0]            rs2Val,
    input  wire logic                  wbEn,
    input  wire logic [REG_ADDR_W-1:0] wbAddr,
    input  wire logic [XLEN-1:0]       wbData
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wbLive;

    assign wbLive = wbEn && !reset && (wbAddr != '0);  // x0 is never written

    always_ff @(posedge clk) begin
        if (reset) begin
            regs[0] <= '0;  // x0 stays zero from here on
        end else if (wbLive) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Reads see a write from the same cycle
    assign rs1Val = (wbLive && wbAddr == rs1Addr) ? wbData : regs[rs1Addr];
    assign rs2Val = (wbLive && wbAddr == rs2Addr) ? wbData : regs[rs2Addr];

    // x0 reads as zero on both ports
    x0ReadsZero: assert property (@(posedge clk) disable iff (reset)
        ((rs1Addr == '0) |-> (rs1Val == '0)) and ((rs2Addr == '0) |-> (rs2Val == '0)))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

/* idExReg.sv */
`default_nettype none

module idExReg import pipePkg::*; (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          pause,
    input  wire logic          flush,
    input  ctrlBundleT         idCtrl,
    input  operandBundleT      idOperands,
    output ctrlBundleT         exCtrl,
    output operandBundleT      exOperands
);

    logic insertBubble;

    // Load-use hold and a taken transfer both leave a hole in EX
    assign insertBubble = pause || flush;

    // ----------------------------------------------------------------------
    // Control bundle
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || insertBubble) begin
            exCtrl <= BUBBLE_CTRL;
        end else begin
            exCtrl <= idCtrl;
        end
    end

    // ----------------------------------------------------------------------
    // Operand bundle
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || insertBubble) begin
            exOperands <= '0;  // Keeps a bubble's rd and pc clean
        end else begin
            exOperands <= idOperands;
        end
    end

    // A bubble must not reach any architectural write
    bubbleHasNoWrites: assert property (@(posedge clk) disable iff (reset)
        insertBubble |=> (!exCtrl.regWrite && !exCtrl.memWrite))
        else $error("write enable leaked through a bubble");

endmodule

`default_nettype wire

/* execUnit.sv */
`default_nettype none

module execUnit import riscvPkg::*; import pipePkg::*; (
    input  ctrlBundleT    exCtrl,
    input  operandBundleT exOperands,
    output exResultT      exResult,
    output logic          exValid,
    output redirectT      redirect
);

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluOut;
    logic [XLEN-1:0] jalrSum;
    logic [4:0]      shamt;
    logic            condMet;

    assign opA   = exOperands.rs1Val;
    assign opB   = exCtrl.aluSrcImm ? exOperands.imm : exOperands.rs2Val;
    assign shamt = opB[4:0];

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------
    always_comb begin
        case (exCtrl.aluOp)
            ALU_ADD:   aluOut = opA + opB;
            ALU_SUB:   aluOut = opA - opB;
            ALU_SLL:   aluOut = opA << shamt;
            ALU_SLT:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
            ALU_SLTU:  aluOut = {31'b0, opA < opB};
            ALU_XOR:   aluOut = opA ^ opB;
            ALU_SRL:   aluOut = opA >> shamt;
            ALU_SRA:   aluOut = $unsigned($signed(opA) >>> shamt);
            ALU_OR:    aluOut = opA | opB;
            ALU_AND:   aluOut = opA & opB;
            ALU_PASSB: aluOut = opB;
            default:   aluOut = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Branch compare and target
    // ----------------------------------------------------------------------
    always_comb begin
        case (exCtrl.branchCond)
            BR_BEQ:  condMet = (exOperands.rs1Val == exOperands.rs2Val);
            BR_BNE:  condMet = (exOperands.rs1Val != exOperands.rs2Val);
            BR_BLT:  condMet = ($signed(exOperands.rs1Val) < $signed(exOperands.rs2Val));
            BR_BGE:  condMet = ($signed(exOperands.rs1Val) >= $signed(exOperands.rs2Val));
            BR_BLTU: condMet = (exOperands.rs1Val < exOperands.rs2Val);
            BR_BGEU: condMet = (exOperands.rs1Val >= exOperands.rs2Val);
            default: condMet = 1'b0;  // funct3 010/011 never branch
        endcase
    end

    assign jalrSum = exOperands.rs1Val + exOperands.imm;

    assign redirect.taken  = exCtrl.jump || (exCtrl.branch && condMet);
    assign redirect.target = exCtrl.jalr ? {jalrSum[XLEN-1:1], 1'b0}
                                         : exOperands.pc + exOperands.imm;

    // Results toward MEM, jumps hand back the link address
    assign exResult.aluResult = exCtrl.jump ? exOperands.pc + PC_STEP : aluOut;
    assign exResult.storeData = exOperands.rs2Val;
    assign exResult.rdAddr    = exOperands.rdAddr;
    assign exResult.regWrite  = exCtrl.regWrite;
    assign exResult.memRead   = exCtrl.memRead;
    assign exResult.memWrite  = exCtrl.memWrite;
    assign exResult.memToReg  = exCtrl.memToReg;

    assign exValid = (exCtrl != BUBBLE_CTRL);

    // A redirect comes from exactly one kind of control transfer
    always_comb begin
        assert (!redirect.taken || (exCtrl.branch ^ exCtrl.jump))
            else $error("redirect without a single branch or jump in EX");
    end

endmodule

`default_nettype wire

/* hazardUnit.sv */
`default_nettype none

module hazardUnit import riscvPkg::*; (
    input  wire logic                  exMemRead,
    input  wire logic [REG_ADDR_W-1:0] exRdAddr,
    input  wire logic [REG_ADDR_W-1:0] rs1Addr,
    input  wire logic [REG_ADDR_W-1:0] rs2Addr,
    input  wire logic                  rs1Used,
    input  wire logic                  rs2Used,
    input  wire logic                  redirectTaken,
    output logic                       pause,
    output logic                       flush,
    output logic                       stall
);

    logic rs1Hit;
    logic rs2Hit;

    // Load in EX whose rd is a real source of the instruction in ID
    assign rs1Hit = rs1Used && (rs1Addr == exRdAddr);
    assign rs2Hit = rs2Used && (rs2Addr == exRdAddr);

    assign pause = exMemRead && (exRdAddr != '0) && (rs1Hit || rs2Hit);
    assign flush = redirectTaken;  // ID slot is on the wrong path
    assign stall = pause;          // Fetch holds for the same cycle

    // A load in EX never redirects, so the two never meet
    always_comb begin
        assert (!(pause && flush))
            else $error("pause and flush together, load raised a redirect");
    end

endmodule

`default_nettype wire

/* decodeExecute.sv */
`default_nettype none

module decodeExecute import riscvPkg::*; import pipePkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [XLEN-1:0]       instr,
    input  wire logic [XLEN-1:0]       pc,
    input  wire logic                  instrValid,
    input  wire logic                  wbEn,
    input  wire logic [REG_ADDR_W-1:0] wbAddr,
    input  wire logic [XLEN-1:0]       wbData,
    output logic                       stall,
    output exResultT                   exResult,
    output logic                       exValid,
    output redirectT                   redirect
);

    // ----------------------------------------------------------------------
    // ID stage
    // ----------------------------------------------------------------------
    ctrlBundleT            idCtrl;
    operandBundleT         idOperands;
    logic [XLEN-1:0]       idImm;
    logic [REG_ADDR_W-1:0] idRs1Addr;
    logic [REG_ADDR_W-1:0] idRs2Addr;
    logic [REG_ADDR_W-1:0] idRdAddr;
    logic [XLEN-1:0]       idRs1Val;
    logic [XLEN-1:0]       idRs2Val;
    logic                  idRs1Used;
    logic                  idRs2Used;

    // EX stage and hazard
    ctrlBundleT            exCtrl;
    operandBundleT         exOperands;
    logic                  pause;
    logic                  flush;

    instrDecoder uDecoder (
        .instr(instr), .instrValid(instrValid), .ctrl(idCtrl), .imm(idImm),
        .rs1Addr(idRs1Addr), .rs2Addr(idRs2Addr), .rdAddr(idRdAddr),
        .rs1Used(idRs1Used), .rs2Used(idRs2Used)
    );

    regFile uRegFile (
        .clk(clk), .reset(reset), .rs1Addr(idRs1Addr), .rs2Addr(idRs2Addr),
        .rs1Val(idRs1Val), .rs2Val(idRs2Val),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    assign idOperands = '{pc: pc, rs1Addr: idRs1Addr, rs2Addr: idRs2Addr, rdAddr: idRdAddr,
                          rs1Val: idRs1Val, rs2Val: idRs2Val, imm: idImm};

    hazardUnit uHazard (
        .exMemRead(exCtrl.memRead), .exRdAddr(exOperands.rdAddr),
        .rs1Addr(idRs1Addr), .rs2Addr(idRs2Addr), .rs1Used(idRs1Used), .rs2Used(idRs2Used),
        .redirectTaken(redirect.taken), .pause(pause), .flush(flush), .stall(stall)
    );

    idExReg uIdEx (
        .clk(clk), .reset(reset), .pause(pause), .flush(flush),
        .idCtrl(idCtrl), .idOperands(idOperands), .exCtrl(exCtrl), .exOperands(exOperands)
    );

    execUnit uExec (
        .exCtrl(exCtrl), .exOperands(exOperands), .exResult(exResult),
        .exValid(exValid), .redirect(redirect)
    );

endmodule

`default_nettype wire

/* tbDecodeExecute.sv */
`default_nettype none

module tbDecodeExecute import riscvPkg::*; import pipePkg::*; ();

    localparam int REC_WORDS    = 7;    // ctrl instr pc wbData alu store target
    localparam int MAX_RECORDS  = 64;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 4;

    // Bits of the record control word
    localparam int B_INSTR  = 0;
    localparam int B_WB     = 1;
    localparam int B_SQUASH = 4;
    localparam int B_STALL  = 5;
    localparam int B_REGW   = 8;
    localparam int B_MEMRD  = 9;
    localparam int B_MEMWR  = 10;
    localparam int B_TAKEN  = 11;

    // One expected EX result, kept in program order
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       storeData;
        logic [XLEN-1:0]       target;
        logic [REG_ADDR_W-1:0] rdAddr;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  memToReg;
        logic                  taken;
    } expectT;

    logic                  clk;
    logic                  reset;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       pc;
    logic                  instrValid;
    logic                  wbEn;
    logic [REG_ADDR_W-1:0] wbAddr;
    logic [XLEN-1:0]       wbData;
    logic                  stall;
    exResultT              exResult;
    logic                  exValid;
    redirectT              redirect;

    logic [XLEN-1:0] stimMem [MAX_RECORDS*REC_WORDS];
    expectT          expQueue [$];
    int              numRecords    = 0;
    int              cycleLimit    = 0;
    int              cycleCount    = 0;
    int              mismatchCount = 0;
    int              failCount     = 0;

    decodeExecute dut (
        .clk(clk), .reset(reset), .instr(instr), .pc(pc), .instrValid(instrValid),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .stall(stall),
        .exResult(exResult), .exValid(exValid), .redirect(redirect)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ----------------------------------------------------------------------
    // Record handling
    // ----------------------------------------------------------------------
    task automatic driveRecord(input int r);
        logic [XLEN-1:0] c;
        c = (r < numRecords) ? stimMem[r*REC_WORDS] : '0;  // Past the end means idle
        instrValid <= c[B_INSTR];
        instr      <= c[B_INSTR] ? stimMem[r*REC_WORDS+1] : NOP_INSTR;
        pc         <= c[B_INSTR] ? stimMem[r*REC_WORDS+2] : '0;
        wbEn       <= c[B_WB];
        wbAddr     <= c[28:24];
        wbData     <= c[B_WB] ? stimMem[r*REC_WORDS+3] : '0;
    endtask

    function automatic expectT expectFromRecord(input int r);
        expectT          e;
        logic [XLEN-1:0] c;
        c           = stimMem[r*REC_WORDS];
        e.pc        = stimMem[r*REC_WORDS+2];
        e.aluResult = stimMem[r*REC_WORDS+4];
        e.storeData = stimMem[r*REC_WORDS+5];
        e.target    = stimMem[r*REC_WORDS+6];
        e.rdAddr    = c[20:16];
        e.regWrite  = c[B_REGW];
        e.memRead   = c[B_MEMRD];
        e.memWrite  = c[B_MEMWR];
        e.memToReg  = c[B_MEMRD];  // Only loads write back memory data
        e.taken     = c[B_TAKEN];
        return e;
    endfunction

    // ----------------------------------------------------------------------
    // Output checks
    // ----------------------------------------------------------------------
    task automatic compareResult(input expectT e);
        logic [4:0] gotFlags;
        logic [4:0] expFlags;
        gotFlags = {exResult.regWrite, exResult.memRead, exResult.memWrite,
                    exResult.memToReg, redirect.taken};
        expFlags = {e.regWrite, e.memRead, e.memWrite, e.memToReg, e.taken};
        assert (gotFlags == expFlags) else begin
            $display("MISMATCH at %0t: pc %h regWrite/memRead/memWrite/memToReg/taken %b, %s %b",
                     $time, e.pc, gotFlags, "expected", expFlags);
            mismatchCount++;
        end
        assert (exResult.rdAddr == e.rdAddr) else begin
            $display("MISMATCH at %0t: pc %h rdAddr %0d, expected %0d",
                     $time, e.pc, exResult.rdAddr, e.rdAddr);
            mismatchCount++;
        end
        // Branches carry no meaningful ALU result
        assert (!(e.regWrite || e.memRead || e.memWrite) || exResult.aluResult == e.aluResult)
        else begin
            $display("MISMATCH at %0t: pc %h aluResult %h, expected %h",
                     $time, e.pc, exResult.aluResult, e.aluResult);
            mismatchCount++;
        end
        assert (!e.memWrite || exResult.storeData == e.storeData) else begin
            $display("MISMATCH at %0t: pc %h storeData %h, expected %h",
                     $time, e.pc, exResult.storeData, e.storeData);
            mismatchCount++;
        end
        assert (!e.taken || redirect.target == e.target) else begin
            $display("MISMATCH at %0t: pc %h redirect target %h, expected %h",
                     $time, e.pc, redirect.target, e.target);
            mismatchCount++;
        end
    endtask

    task automatic checkOutputs();
        expectT e;
        if (exValid) begin
            assert (expQueue.size() != 0) else begin
                $display("Unexpected exValid at %0t with no result pending", $time);
                failCount++;
            end
            if (expQueue.size() != 0) begin
                e = expQueue.pop_front();
                compareResult(e);
            end
        end else begin
            assert (!redirect.taken) else begin
                $display("Redirect raised at %0t with a bubble in EX", $time);
                failCount++;
            end
        end
    endtask

    task automatic printSummary();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
    endtask

    // Watchdog on the cycle count
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: run still busy after %0d cycles", cycleCount);
            printSummary();
            $display("Test failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int              rec;
        logic [XLEN-1:0] ctrlWord;
        logic            heldOnce;

        reset      <= 1'b1;
        instr      <= NOP_INSTR;
        pc         <= '0;
        instrValid <= 1'b0;
        wbEn       <= 1'b0;
        wbAddr     <= '0;
        wbData     <= '0;

        foreach (stimMem[i]) stimMem[i] = '0;
        $readmemh("stimDecodeExecute.txt", stimMem);
        while (numRecords < MAX_RECORDS && stimMem[numRecords*REC_WORDS][3:0] != 4'h0) begin
            numRecords++;
        end
        cycleLimit = 4 * numRecords + 50;
        assert (numRecords > 0) else begin
            $display("No records found in the stimulus file");
            failCount++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // First cycle out of reset must be empty
        @(posedge clk);
        assert (!exValid && !redirect.taken && !stall) else begin
            $display("Outputs not idle in the first cycle after reset");
            failCount++;
        end

        rec      = 0;
        heldOnce = 1'b0;
        driveRecord(rec);
        while (rec < numRecords) begin
            @(posedge clk);
            checkOutputs();
            ctrlWord = stimMem[rec*REC_WORDS];
            if (stall) begin
                assert (ctrlWord[B_STALL] && !heldOnce) else begin
                    $display("Unexpected stall at %0t while holding record %0d", $time, rec);
                    failCount++;
                end
                heldOnce = 1'b1;  // Inputs stay as they are
            end else begin
                assert (!ctrlWord[B_STALL] || heldOnce) else begin
                    $display("Record %0d was accepted without its load-use stall", rec);
                    failCount++;
                end
                assert (redirect.taken == (ctrlWord[B_INSTR] && ctrlWord[B_SQUASH])) else begin
                    $display("Redirect at %0t disagrees with squash flag of record %0d",
                             $time, rec);
                    failCount++;
                end
                if (ctrlWord[B_INSTR] && !ctrlWord[B_SQUASH]) begin
                    expQueue.push_back(expectFromRecord(rec));
                end
                rec++;
                heldOnce = 1'b0;
                driveRecord(rec);
            end
        end

        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            checkOutputs();
        end
        assert (expQueue.size() == 0) else begin
            $display("Expected queue not empty at end, %0d results never arrived",
                     expQueue.size());
            failCount++;
        end

        printSummary();
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* stimDecodeExecute.txt */
// Columns: ctrl instr pc wbData expAluResult expStoreData expTarget
// ctrl: [28:24] wbAddr [20:16] rd [11] taken [10] memWr [9] memRd [8] regWr [5] stall [4] squash [1] wb [0] instr
01000002 00000000 00000000 00000005 00000000 00000000 00000000
02000002 00000000 00000000 FFFFFFF0 00000000 00000000 00000000
03000002 00000000 00000000 80000000 00000000 00000000 00000000
04000002 00000000 00000000 00000010 00000000 00000000 00000000
05000002 00000000 00000000 00000003 00000000 00000000 00000000
10000002 00000000 00000000 00000100 00000000 00000000 00000000
00000002 00000000 00000000 12345678 00000000 00000000 00000000
// add sub slt sltu sra srl xori srai andi-to-x0 lui
00060101 00208333 00000100 00000000 FFFFFFF5 00000000 00000000
00070101 402083B3 00000104 00000000 00000015 00000000 00000000
00080101 00112433 00000108 00000000 00000001 00000000 00000000
00090101 001134B3 0000010C 00000000 00000000 00000000 00000000
000A0101 4051D533 00000110 00000000 F0000000 00000000 00000000
000B0101 0051D5B3 00000114 00000000 10000000 00000000 00000000
000C0101 FFF0C613 00000118 00000000 FFFFFFFA 00000000 00000000
000D0101 40215693 0000011C 00000000 FFFFFFFC 00000000 00000000
00000101 0070F013 00000120 00000000 00000005 00000000 00000000
000F0101 123457B7 00000124 00000000 12345000 00000000 00000000
// sw, lw with dependent add, lw x0 with add reading x0
00000401 00122423 00000128 00000000 00000018 00000005 00000000
00100301 00422803 0000012C 00000000 00000014 00000000 00000000
00110121 001808B3 00000130 00000000 00000105 00000000 00000000
00000301 00022003 00000134 00000000 00000010 00000000 00000000
000E0101 00100733 00000138 00000000 00000005 00000000 00000000
// beq not taken, blt taken, jal, jalr, each taken one squashes the next slot
00000001 00508463 0000013C 00000000 00000000 00000000 00000000
00120101 00108913 00000140 00000000 00000006 00000000 00000000
00000801 00114663 00000144 00000000 00000000 00000000 00000150
00000011 00208993 00000148 00000000 00000000 00000000 00000000
00140901 01000A6F 00000150 00000000 00000154 00000000 00000160
00000011 00208993 00000154 00000000 00000000 00000000 00000000
00150901 02120AE7 00000160 00000000 00000164 00000000 00000030
00000011 00208993 00000164 00000000 00000000 00000000 00000000
// add reading x23 while x23 is written in the same cycle
17160103 001B8B33 00000030 00000700 00000705 00000000 00000000

/* vlog.f */
riscvPkg.sv
pipePkg.sv
instrDecoder.sv
regFile.sv
idExReg.sv
execUnit.sv
hazardUnit.sv
decodeExecute.sv
tbDecodeExecute.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the decode/execute testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
    --top-module tbDecodeExecute -f vlog.f -o simDecodeExecute

./obj_dir/simDecodeExecute > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Test passed" "$LOG"; then
    echo "Simulation PASS"
    exit 0
fi
echo "Simulation FAIL, see $LOG"
exit 1
